// File: dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_checker.sv
testbench/dcache_monitor.sv
testbench/dcache_tb.sv

// File: hdl/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int unsigned       NR_WAYS          = 2,
    parameter dcache_pkg::addr_t CACHE_START_ADDR = 32'h0000_1000
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // core port
    input  logic                 req_i,
    input  logic                 we_i,
    input  dcache_pkg::addr_t    addr_i,
    input  dcache_pkg::word_t    wdata_i,
    input  dcache_pkg::word_be_t be_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output dcache_pkg::word_t    rdata_o,
    // array side
    output dcache_pkg::index_t   arr_index_o,
    output dcache_pkg::tag_t     arr_tag_o,
    output logic                 arr_word_sel_o,
    output logic [NR_WAYS-1:0]   arr_we_way_o,
    output dcache_pkg::line_t    arr_wdata_o,
    output dcache_pkg::line_be_t arr_wbe_o,
    input  logic [NR_WAYS-1:0]   hit_way_i,
    input  dcache_pkg::word_t    arr_rdata_i,
    // memory port
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::word_t    mem_wdata_o,
    output dcache_pkg::word_be_t mem_be_o,
    input  logic                 mem_gnt_i,
    input  logic                 mem_rvalid_i,
    input  dcache_pkg::line_t    mem_rdata_i
);

    import dcache_pkg::*;

    localparam int unsigned VICTIM_WIDTH = (NR_WAYS > 1) ? $clog2(NR_WAYS) : 1;

    ctrl_state_e state_d, state_q;

    // captured request record
    addr_t    addr_d, addr_q;
    word_t    wdata_d, wdata_q;
    word_be_t be_d, be_q;
    logic     we_d, we_q;
    logic     bypass_d, bypass_q;

    logic [NR_WAYS-1:0]      hit_way_d, hit_way_q;
    logic [VICTIM_WIDTH-1:0] victim_d, victim_q;
    logic [NR_WAYS-1:0]      victim_way;
    line_t                   line_d, line_q;
    logic                    word_sel;
    line_be_t                store_be;

    function automatic word_t line_half(line_t line, logic sel);
        return sel ? line[WORD_WIDTH +: WORD_WIDTH] : line[0 +: WORD_WIDTH];
    endfunction

    assign word_sel  = addr_q[WORD_SEL_BIT];
    assign arr_tag_o = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    // store bytes placed in the addressed half of the line
    assign store_be  = word_sel ? {be_q, {WORD_BYTES{1'b0}}} : {{WORD_BYTES{1'b0}}, be_q};

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            victim_way[w] = (victim_q == VICTIM_WIDTH'(w));
        end
    end

    // memory fields come straight from the record, stable while mem_req_o waits
    // writes go out word aligned, reads fetch the whole line
    assign mem_we_o    = we_q;
    assign mem_addr_o  = we_q ? {addr_q[ADDR_WIDTH-1:WORD_SEL_BIT], {WORD_SEL_BIT{1'b0}}}
                              : {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign mem_wdata_o = wdata_q;
    assign mem_be_o    = be_q;

    // ------------------------------------------------------------
    // controller FSM
    // ------------------------------------------------------------
    always_comb begin : ctrl_fsm
        state_d   = state_q;
        addr_d    = addr_q;
        wdata_d   = wdata_q;
        be_d      = be_q;
        we_d      = we_q;
        bypass_d  = bypass_q;
        hit_way_d = hit_way_q;
        victim_d  = victim_q;
        line_d    = line_q;

        gnt_o    = 1'b0;
        rvalid_o = 1'b0;
        rdata_o  = '0;

        arr_index_o    = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
        arr_word_sel_o = word_sel;
        arr_we_way_o   = '0;
        arr_wdata_o    = '0;
        arr_wbe_o      = '0;
        mem_req_o      = 1'b0;

        case (state_q)
            IDLE: begin
                // arrays see the incoming index right away
                arr_index_o    = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
                arr_word_sel_o = addr_i[WORD_SEL_BIT];
                if (req_i) begin
                    addr_d   = addr_i;
                    wdata_d  = wdata_i;
                    be_d     = be_i;
                    we_d     = we_i;
                    bypass_d = (addr_i < CACHE_START_ADDR);
                    // loads granted now, stores once memory takes them
                    gnt_o    = ~we_i;
                    // uncached range skips the lookup
                    state_d  = (addr_i < CACHE_START_ADDR) ? MEM_REQ : LOOKUP;
                end
            end

            LOOKUP: begin
                if (|hit_way_i) begin
                    if (we_q) begin
                        hit_way_d = hit_way_i;
                        state_d   = STORE_HIT;
                    end else begin
                        rvalid_o = 1'b1;
                        rdata_o  = arr_rdata_i;
                        state_d  = IDLE;
                    end
                end else begin
                    // load miss refills, store miss writes around the cache
                    state_d = MEM_REQ;
                end
            end

            STORE_HIT: begin
                arr_we_way_o = hit_way_q;
                arr_wdata_o  = {wdata_q, wdata_q};
                arr_wbe_o    = store_be;
                // write-through
                state_d      = MEM_REQ;
            end

            MEM_REQ: begin
                mem_req_o = 1'b1;
                if (mem_gnt_i) begin
                    if (we_q) begin
                        gnt_o   = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = MEM_WAIT;
                    end
                end
            end

            MEM_WAIT: begin
                if (mem_rvalid_i) begin
                    if (bypass_q) begin
                        rvalid_o = 1'b1;
                        rdata_o  = line_half(mem_rdata_i, word_sel);
                        state_d  = IDLE;
                    end else begin
                        line_d  = mem_rdata_i;
                        state_d = REFILL;
                    end
                end
            end

            REFILL: begin
                // whole line into the victim, tag array takes the tag too
                arr_we_way_o = victim_way;
                arr_wdata_o  = line_q;
                arr_wbe_o    = '1;
                victim_d     = (victim_q == VICTIM_WIDTH'(NR_WAYS - 1)) ? '0 : victim_q + 1'b1;
                rvalid_o     = 1'b1;
                rdata_o      = line_half(line_q, word_sel);
                state_d      = IDLE;
            end

            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            we_q      <= 1'b0;
            bypass_q  <= 1'b0;
            hit_way_q <= '0;
            victim_q  <= '0;
        end else begin
            state_q   <= state_d;
            we_q      <= we_d;
            bypass_q  <= bypass_d;
            hit_way_q <= hit_way_d;
            victim_q  <= victim_d;
        end
    end

    // request payload and refill line
    always_ff @(posedge clk_i) begin
        addr_q  <= addr_d;
        wdata_q <= wdata_d;
        be_q    <= be_d;
        line_q  <= line_d;
    end

endmodule

// File: hdl/dcache_data_array.sv
module dcache_data_array #(
    parameter int unsigned NR_WAYS = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  dcache_pkg::index_t   index_i,
    input  logic                 word_sel_i,
    input  logic [NR_WAYS-1:0]   way_sel_i,
    input  logic [NR_WAYS-1:0]   we_way_i,
    input  dcache_pkg::line_t    wdata_i,
    input  dcache_pkg::line_be_t wbe_i,
    output dcache_pkg::word_t    rdata_o
);

    import dcache_pkg::*;

    localparam int unsigned NR_SETS = 2 ** INDEX_WIDTH;

    // lines kept as bytes so the byte enables map directly
    logic [LINE_BYTES-1:0][7:0] line_mem [NR_WAYS][NR_SETS];

    index_t index_q;
    logic   word_sel_q;
    line_t  way_line;

    // read address registered, data is out one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            index_q    <= '0;
            word_sel_q <= 1'b0;
        end else begin
            index_q    <= index_i;
            word_sel_q <= word_sel_i;
        end
    end

    // byte-enabled write into every enabled way
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NR_WAYS; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (we_way_i[w] && wbe_i[b]) begin
                    line_mem[w][index_i][b] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // way select, way_sel_i is one-hot or zero
    always_comb begin
        way_line = '0;
        for (int w = 0; w < NR_WAYS; w++) begin
            if (way_sel_i[w]) begin
                way_line = way_line | line_mem[w][index_q];
            end
        end
    end

    // offset select, upper or lower half of the line
    assign rdata_o = word_sel_q ? way_line[WORD_WIDTH +: WORD_WIDTH] : way_line[0 +: WORD_WIDTH];

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // ------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------
    localparam int unsigned ADDR_WIDTH   = 32;
    localparam int unsigned WORD_WIDTH   = 64;
    localparam int unsigned LINE_WIDTH   = 128;
    localparam int unsigned WORD_BYTES   = WORD_WIDTH / 8;
    localparam int unsigned LINE_BYTES   = LINE_WIDTH / 8;

    // address split: | tag | index | offset |
    localparam int unsigned OFFSET_WIDTH = 4;
    localparam int unsigned INDEX_WIDTH  = 4;
    localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // address bit that picks the upper or lower word of a line
    localparam int unsigned WORD_SEL_BIT = $clog2(WORD_BYTES);

    // ------------------------------------------------------------
    // width types
    // ------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [WORD_BYTES-1:0]  word_be_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;
    typedef logic [LINE_BYTES-1:0]  line_be_t;

    // ------------------------------------------------------------
    // controller states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,       // waiting for a core request
        LOOKUP,     // tag compare of the captured request
        STORE_HIT,  // second array access, writes the store into the hit way
        MEM_REQ,    // memory request held until granted
        MEM_WAIT,   // waiting for the read line from memory
        REFILL      // victim way written, load answered
    } ctrl_state_e;

endpackage

// File: hdl/dcache_tag_array.sv
module dcache_tag_array #(
    parameter int unsigned NR_WAYS = 2
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  dcache_pkg::index_t index_i,
    input  dcache_pkg::tag_t   tag_i,
    input  logic [NR_WAYS-1:0] we_way_i,
    output logic [NR_WAYS-1:0] hit_way_o
);

    import dcache_pkg::*;

    localparam int unsigned NR_SETS = 2 ** INDEX_WIDTH;

    // one valid bit per set, per way
    logic [NR_SETS-1:0] valid_q [NR_WAYS];
    tag_t               tag_mem [NR_WAYS][NR_SETS];

    // lookup index, compare happens one cycle after the address
    index_t index_q;

    // ------------------------------------------------------------
    // valid bits and read index
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            index_q <= '0;
            for (int w = 0; w < NR_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            index_q <= index_i;
            // a written way becomes valid
            for (int w = 0; w < NR_WAYS; w++) begin
                if (we_way_i[w]) begin
                    valid_q[w][index_i] <= 1'b1;
                end
            end
        end
    end

    // tag storage
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NR_WAYS; w++) begin
            if (we_way_i[w]) begin
                tag_mem[w][index_i] <= tag_i;
            end
        end
    end

    // parallel compare over all ways, one-hot when tags are unique per set
    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            hit_way_o[w] = valid_q[w][index_q] && (tag_mem[w][index_q] == tag_i);
        end
    end

endmodule

// File: hdl/dcache_top.sv
module dcache_top #(
    parameter int unsigned       NR_WAYS          = 2,
    parameter dcache_pkg::addr_t CACHE_START_ADDR = 32'h0000_1000
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // core port
    input  logic                 req_i,
    input  logic                 we_i,
    input  dcache_pkg::addr_t    addr_i,
    input  dcache_pkg::word_t    wdata_i,
    input  dcache_pkg::word_be_t be_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output dcache_pkg::word_t    rdata_o,
    // memory port
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::word_t    mem_wdata_o,
    output dcache_pkg::word_be_t mem_be_o,
    input  logic                 mem_gnt_i,
    input  logic                 mem_rvalid_i,
    input  dcache_pkg::line_t    mem_rdata_i
);

    import dcache_pkg::*;

    // ------------------------------------------------------------
    // controller to array wiring
    // ------------------------------------------------------------
    index_t             arr_index;
    tag_t               arr_tag;
    logic               arr_word_sel;
    logic [NR_WAYS-1:0] arr_we_way;
    line_t              arr_wdata;
    line_be_t           arr_wbe;
    // hit vector feeds both the controller and the way select
    logic [NR_WAYS-1:0] hit_way;
    word_t              arr_rdata;

    dcache_ctrl #(
        .NR_WAYS          (NR_WAYS),
        .CACHE_START_ADDR (CACHE_START_ADDR)
    ) i_ctrl (
        .clk_i, .rst_ni,
        .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o, .rvalid_o, .rdata_o,
        .arr_index_o    (arr_index),
        .arr_tag_o      (arr_tag),
        .arr_word_sel_o (arr_word_sel),
        .arr_we_way_o   (arr_we_way),
        .arr_wdata_o    (arr_wdata),
        .arr_wbe_o      (arr_wbe),
        .hit_way_i      (hit_way),
        .arr_rdata_i    (arr_rdata),
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_be_o,
        .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
    );

    dcache_tag_array #(.NR_WAYS(NR_WAYS)) i_tag_array (
        .clk_i, .rst_ni,
        .index_i   (arr_index),
        .tag_i     (arr_tag),
        .we_way_i  (arr_we_way),
        .hit_way_o (hit_way)
    );

    dcache_data_array #(.NR_WAYS(NR_WAYS)) i_data_array (
        .clk_i, .rst_ni,
        .index_i    (arr_index),
        .word_sel_i (arr_word_sel),
        .way_sel_i  (hit_way),
        .we_way_i   (arr_we_way),
        .wdata_i    (arr_wdata),
        .wbe_i      (arr_wbe),
        .rdata_o    (arr_rdata)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f dcache_top.f --top-module dcache_tb -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1

// File: testbench/dcache_checker.sv
module dcache_checker (
    input logic                    clk_i,
    input logic                    rst_ni,
    input dcache_pkg::ctrl_state_e state_q,
    input logic                    gnt_o,
    input logic                    rvalid_o,
    input logic                    mem_req_o,
    input logic                    mem_gnt_i,
    input dcache_pkg::addr_t       mem_addr_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    // number of failed assertions
    int n_errors = 0;

    // no load answer can leave the controller while it waits for a request
    a_no_rvalid_in_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (state_q == IDLE) |-> !rvalid_o
    ) else begin
        $error("rvalid_o high while the controller is in IDLE");
        n_errors = n_errors + 1;
    end

    // memory request held with a stable address until granted
    a_mem_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o))
    ) else begin
        $error("mem_req_o dropped or mem_addr_o changed before mem_gnt_i");
        n_errors = n_errors + 1;
    end

    // one grant per request
    a_gnt_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) gnt_o |=> !gnt_o
    ) else begin
        $error("gnt_o high for two consecutive cycles");
        n_errors = n_errors + 1;
    end

endmodule

// File: testbench/dcache_input.txt
# op (0 load, 1 store)  address  write data  byte enables  expected read data  latency
# latency counts cycles from gnt_o to rvalid_o, 0 means not checked
0 00002000 0000000000000000 00 5a5a000000002000 0
0 00002000 0000000000000000 00 5a5a000000002000 1
0 00002008 0000000000000000 00 5a5a000000002008 1
1 00002008 1122334455667788 0f 0000000000000000 0
0 00002008 0000000000000000 00 5a5a000055667788 1
1 00003010 aabbccddeeff0011 f0 0000000000000000 0
0 00003010 0000000000000000 00 aabbccdd00003010 0
0 00000100 0000000000000000 00 5a5a000000000100 0
1 00000108 0123456789abcdef ff 0000000000000000 0
0 00000108 0000000000000000 00 0123456789abcdef 0
0 00004020 0000000000000000 00 5a5a000000004020 0
0 00005020 0000000000000000 00 5a5a000000005020 0
0 00006028 0000000000000000 00 5a5a000000006028 0
0 00004028 0000000000000000 00 5a5a000000004028 0
0 00005020 0000000000000000 00 5a5a000000005020 0
0 00006020 0000000000000000 00 5a5a000000006020 0

// File: testbench/dcache_monitor.sv
module dcache_monitor (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  logic              gnt_o,
    input  logic              rvalid_o,
    input  dcache_pkg::word_t rdata_o,
    input  dcache_pkg::word_t exp_rdata_i,
    input  int                exp_lat_i,
    output int                n_done_o,
    output int                n_fail_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    int    cycle;
    int    gnt_cycle;
    logic  load_open;
    addr_t load_addr;
    logic  test_ok;

    // core port sampled at the rising edge, before any register update lands
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle     = 0;
            load_open = 1'b0;
            n_done_o  = 0;
            n_fail_o  = 0;
        end else begin
            cycle = cycle + 1;
            // answer to an earlier load
            if (rvalid_o) begin
                test_ok = 1'b1;
                if (!load_open) begin
                    $display("rvalid_o at %0t with no load outstanding", $time);
                    test_ok = 1'b0;
                end else begin
                    if (rdata_o !== exp_rdata_i) begin
                        $display("CHECK FAILED at %0t: rdata_o expected %h, got %h",
                                 $time, exp_rdata_i, rdata_o);
                        test_ok = 1'b0;
                    end
                    // latency 0 in the input file means any latency is fine
                    if (exp_lat_i != 0 && (cycle - gnt_cycle) != exp_lat_i) begin
                        $display("CHECK FAILED at %0t: rvalid_o latency expected %0d, got %0d",
                                 $time, exp_lat_i, cycle - gnt_cycle);
                        test_ok = 1'b0;
                    end
                end
                load_open = 1'b0;
                n_done_o  = n_done_o + 1;
                if (!test_ok) begin
                    n_fail_o = n_fail_o + 1;
                end
                $display("test %0d: load  %h %s", n_done_o, load_addr, test_ok ? "ok" : "failed");
            end
            // granted request
            if (req_i && gnt_o) begin
                if (we_i) begin
                    n_done_o = n_done_o + 1;
                    $display("test %0d: store %h ok", n_done_o, addr_i);
                end else begin
                    load_open = 1'b1;
                    load_addr = addr_i;
                    gnt_cycle = cycle;
                end
            end
        end
    end

endmodule

// File: testbench/dcache_tb.sv
module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int CLK_PERIOD = 20;

    logic     clk_i;
    logic     rst_ni;
    logic     req_i;
    logic     we_i;
    addr_t    addr_i;
    word_t    wdata_i;
    word_be_t be_i;
    logic     gnt_o;
    logic     rvalid_o;
    word_t    rdata_o;
    logic     mem_req_o;
    logic     mem_we_o;
    addr_t    mem_addr_o;
    word_t    mem_wdata_o;
    word_be_t mem_be_o;
    logic     mem_gnt_i;
    logic     mem_rvalid_i;
    line_t    mem_rdata_i;

    // current expectation handed to the monitor
    word_t exp_rdata;
    int    exp_lat;
    int    n_done;
    int    n_fail;

    // test table from the input file
    logic     t_we [$];
    addr_t    t_addr [$];
    word_t    t_wdata [$];
    word_be_t t_be [$];
    word_t    t_exp [$];
    int       t_lat [$];
    int       n_tests;

    // memory contents that differ from the fill rule
    word_t mem_written [addr_t];

    dcache_top #(
        .NR_WAYS          (2),
        .CACHE_START_ADDR (32'h0000_1000)
    ) dut (
        .clk_i, .rst_ni,
        .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o, .rvalid_o, .rdata_o,
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_be_o,
        .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
    );

    dcache_monitor i_monitor (
        .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .gnt_o, .rvalid_o, .rdata_o,
        .exp_rdata_i (exp_rdata),
        .exp_lat_i   (exp_lat),
        .n_done_o    (n_done),
        .n_fail_o    (n_fail)
    );

    bind dcache_ctrl dcache_checker i_checker (.*);

    // ------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------
    // low half holds the word's own address and high half a marker
    function automatic word_t mem_word(addr_t a);
        if (mem_written.exists(a)) begin
            return mem_written[a];
        end
        return {32'h5a5a_0000, a};
    endfunction

    task automatic mem_write(addr_t a, word_t d, word_be_t be);
        word_t w;
        w = mem_word(a);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        mem_written[a] = w;
    endtask

    // grant after 1 to 4 cycles and read data 1 to 4 cycles after that
    initial begin : memory_model
        addr_t line_addr;
        void'($urandom(32'hc2bb_2fb5));
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                repeat ($urandom % 4) @(negedge clk_i);
                mem_gnt_i = 1'b1;
                if (mem_we_o) begin
                    mem_write(mem_addr_o, mem_wdata_o, mem_be_o);
                end
                line_addr = {mem_addr_o[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
                @(negedge clk_i);
                mem_gnt_i = 1'b0;
                if (!mem_we_o) begin
                    repeat ($urandom % 4) @(negedge clk_i);
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = {mem_word(line_addr + 8), mem_word(line_addr)};
                    @(negedge clk_i);
                    mem_rvalid_i = 1'b0;
                    mem_rdata_i  = '0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // clock, reset and stimulus
    // ------------------------------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic read_tests();
        int    fd;
        int    op;
        int    lat;
        addr_t a;
        word_t d;
        word_t e;
        int    be;
        string line;
        fd = $fopen("testbench/dcache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/dcache_input.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            // comment and blank lines skipped
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %d", op, a, d, be, e, lat) == 6) begin
                t_we.push_back(op[0]);
                t_addr.push_back(a);
                t_wdata.push_back(d);
                t_be.push_back(be[7:0]);
                t_exp.push_back(e);
                t_lat.push_back(lat);
            end
        end
        $fclose(fd);
    endtask

    // one request held until granted and then the load answer
    task automatic run_test(int idx);
        @(negedge clk_i);
        req_i     = 1'b1;
        we_i      = t_we[idx];
        addr_i    = t_addr[idx];
        wdata_i   = t_wdata[idx];
        be_i      = t_be[idx];
        exp_rdata = t_exp[idx];
        exp_lat   = t_lat[idx];
        #1;
        while (!gnt_o) begin
            @(negedge clk_i);
            #1;
        end
        @(posedge clk_i);
        @(negedge clk_i);
        req_i = 1'b0;
        if (!t_we[idx]) begin
            #1;
            while (!rvalid_o) begin
                @(negedge clk_i);
                #1;
            end
            @(posedge clk_i);
        end
    endtask

    initial begin : stimulus
        rst_ni       = 1'b0;
        req_i        = 1'b0;
        we_i         = 1'b0;
        addr_i       = '0;
        wdata_i      = '0;
        be_i         = '0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        exp_rdata    = '0;
        exp_lat      = 0;
        read_tests();
        n_tests = t_addr.size();
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        repeat (2) @(negedge clk_i);
        $display("tests run %0d of %0d, failed %0d, assertion failures %0d",
                 n_done, n_tests, n_fail, dut.i_ctrl.i_checker.n_errors);
        if (n_tests > 0 && n_fail == 0 && n_done == n_tests
                && dut.i_ctrl.i_checker.n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run limit scales with the number of tests
    initial begin : watchdog
        wait (n_tests > 0);
        repeat (n_tests * 40 + 100) @(posedge clk_i);
        $display("timeout: the tests did not finish in %0d cycles", n_tests * 40 + 100);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
